//--- flist.f
common/rvPkg.sv
hazard/hazardUnit.sv
logic/fetchStage.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/rvCore.sv
dv/tbCore.sv

//--- dv/core_vectors.hex
// Program word count, then program words from address 0
// Then record count, then records of tag (test id in bits 15:8, rd in 4:0) and data
4D
123450B7 00001117 06400193           // lui x1; auipc x2; addi x3,x0,100
FF918213 403202B3 00128293 00528333  // x4=x3-7; x5=x4-x3; x5+=1; x6=x5+x5
03718013 003003B3                    // addi x0,x3,55; add x7,x0,x3
FFF0C413 40445493 00345533           // xori x8,x1,-1; srai x9,x8,4; srl x10,x8,x3
0032A5B3 0032B633 00319693           // slt x11; sltu x12; slli x13,x3,3
0030E733 0F047793                    // or x14,x1,x3; andi x15,x8,0xf0
10000813 00882023 00082883 00188913  // x16=256; sw x8; lw x17; addi x18,x17,1
00180983 00284A03 00281A83           // lb x19,1; lbu x20,2; lh x21,2
00380023 00D81123                    // sb x3,0; sh x13,2
00085B03 00081C03 00082B83 01718D33  // lhu x22; lh x24; lw x23; add x26,x3,x23
00718663 FFF00F93 FFF00F93 00100C93  // beq taken
00518663 002C8C93                    // beq not taken
00519663 FFF00F93 FFF00F93 004C8C93  // bne taken
00719663 008C8C93                    // bne not taken
0032C663 FFF00F93 FFF00F93 010C8C93  // blt taken
0051C663 020C8C93                    // blt not taken
0051D663 FFF00F93 FFF00F93 040C8C93  // bge taken
0032D663 080C8C93                    // bge not taken
0051E663 FFF00F93 FFF00F93 100C8C93  // bltu taken
0032E663 200C8C93                    // bltu not taken
0032F663 FFF00F93 FFF00F93 C00C8C93  // bgeu taken
0051F663 001C8C93                    // bgeu not taken
00C00DEF FFF00F93 FFF00F93           // jal x27,+12
12400E13 005E0EE7 FFF00F93 FFF00F93 FFF00F93  // x28=0x124; jalr x29,5(x28)
00800F6F FFF00F93 01DD8D33           // jal x30,+8; add x26,x27,x29
2B
0101 12345000  0102 00001004  0103 00000064
0204 0000005D  0205 FFFFFFF9  0205 FFFFFFFA  0206 FFFFFFF4
0207 00000064
0108 EDCBAFFF  0109 FEDCBAFF  010A 0EDCBAFF
010B 00000001  010C 00000000  010D 00000320
010E 12345064  010F 000000F0
0310 00000100  0311 EDCBAFFF  0312 EDCBB000
0313 FFFFFFAF  0314 000000CB  0315 FFFFEDCB
0316 0000AF64  0318 FFFFAF64  0317 0320AF64  031A 0320AFC8
0419 00000001  0419 00000003  0419 00000007  0419 0000000F
0419 0000001F  0419 0000003F  0419 0000007F  0419 000000FF
0419 000001FF  0419 000003FF  0419 FFFFFFFF  0419 00000000
051B 0000010C  051C 00000124  051D 0000011C  051E 0000012C
051A 00000228

//--- dv/tbCore.sv
`timescale 1ns/1ps

module tbCore;
    import rvPkg::*;

    localparam int   vecDepth     = 512;
    localparam int   resetCycles  = 4;
    localparam int   settleCycles = 20;
    localparam wordT nopWord      = 32'h0000_0013;

    logic    clk;
    logic    rstN;
    wordT    imemAddr;
    wordT    imemData;
    logic    wbEn;
    regAddrT wbRd;
    wordT    wbData;

    logic [31:0] vecMem [vecDepth]; // Raw contents of the vector file
    int          progWords;
    int          recCount;
    int          recBase;
    int          recIdx;
    int          limitCycles;
    logic [31:0] expTag;
    regAddrT     expRd;
    wordT        expData;

    rvCore dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbEn     (wbEn),
        .wbRd     (wbRd),
        .wbData   (wbData)
    );

    // Instruction word for a byte address, NOP past the end of the program
    function automatic wordT fetchWord(input wordT addr);
        wordT idx;
        idx = addr >> 2;
        if (idx < wordT'(progWords)) begin
            return vecMem[1 + idx];
        end
        return nopWord;
    endfunction

    // Behavior group number from the record tag
    function automatic string testName(input int id);
        case (id)
            1:       return "alu";
            2:       return "forwarding";
            3:       return "load-store";
            4:       return "branch";
            5:       return "jump";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Instruction memory answers on the falling edge
    always @(negedge clk) begin
        imemData <= fetchWord(imemAddr);
    end

    // Every retiring write is matched against the next record in order
    always @(posedge clk) begin
        if (rstN && wbEn) begin
            assert (recIdx < recCount) else begin
                $display("Register x%0d was written after the last expected record", wbRd);
                $display("sim failed");
                $fatal(1, "extra register write");
            end
            expTag  = vecMem[recBase + 2 * recIdx];
            expRd   = expTag[4:0];
            expData = vecMem[recBase + 2 * recIdx + 1];
            assert ((wbRd === expRd) && (wbData === expData)) else begin
                $display("[ERROR] %s record %0d: expected x%0d=%h, actual x%0d=%h",
                         testName(int'(expTag[15:8])), recIdx, expRd, expData, wbRd, wbData);
                $display("sim failed");
                $fatal(1, "writeback mismatch");
            end
            recIdx = recIdx + 1;
        end
    end

    // Run limit scales with program size and trace length
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("Timeout: only %0d of %0d register writes seen within %0d cycles",
                 recIdx, recCount, limitCycles);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rstN        = 1'b0;
        imemData    = nopWord;
        recIdx      = 0;
        recCount    = 0;
        limitCycles = 0;
        $readmemh("dv/core_vectors.hex", vecMem);
        progWords = int'(vecMem[0]);
        assert ((progWords > 0) && (progWords + 2 < vecDepth)) else begin
            $display("The vector file is missing or its program word count is out of range");
            $display("sim failed");
            $fatal(1, "bad vector file");
        end
        recCount = int'(vecMem[progWords + 1]);
        recBase  = progWords + 2;
        assert ((recCount > 0) && (recBase + 2 * recCount <= vecDepth)) else begin
            $display("The vector file record count does not fit the vector memory");
            $display("sim failed");
            $fatal(1, "bad record count");
        end
        limitCycles = 4 * progWords + 8 * recCount + 50;

        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        wait (recIdx == recCount);
        repeat (settleCycles) @(posedge clk); // Any late write fails in the monitor
        $display("sim passed");
        $finish;
    end

endmodule

//--- logic/rvCore.sv
`timescale 1ns/1ps

module rvCore (
    input  logic           clk,
    input  logic           rstN,
    output rvPkg::wordT    imemAddr,
    input  rvPkg::wordT    imemData,
    output logic           wbEn,
    output rvPkg::regAddrT wbRd,
    output rvPkg::wordT    wbData
);
    import rvPkg::*;

    wordT     instrD, pcD, targetE;
    regAddrT  rs1E, rs2E, rdE, rdM, rdW;
    wordT     rd1E, rd2E, immE, pcE;
    aluOpT    aluOpE;
    logic     aluSrcAE, aluSrcBE;
    addrModeT addrModeE, addrModeM;
    branchOpT branchE;
    jumpT     jumpE;
    wbSrcT    wbSrcE, wbSrcM;
    logic     regWriteE, regWriteM;
    wordT     aluResultM, storeDataM, pcPlus4M;
    logic     eqE, ltE, ltuE;
    logic     stall, flush;
    fwdSelT   forwardA, forwardB;

    fetchStage fetch0 (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .targetE(targetE), .imemAddr(imemAddr), .imemData(imemData),
        .instrD(instrD), .pcD(pcD)
    );

    decodeStage decode0 (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .instrD(instrD), .pcD(pcD),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
        .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE),
        .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .pcE(pcE),
        .aluOpE(aluOpE), .aluSrcAE(aluSrcAE), .aluSrcBE(aluSrcBE),
        .addrModeE(addrModeE), .branchE(branchE), .jumpE(jumpE),
        .wbSrcE(wbSrcE), .regWriteE(regWriteE)
    );

    executeStage execute0 (
        .clk(clk), .rstN(rstN), .stall(stall),
        .rdE(rdE), .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .pcE(pcE),
        .aluOpE(aluOpE), .aluSrcAE(aluSrcAE), .aluSrcBE(aluSrcBE),
        .addrModeE(addrModeE), .jumpE(jumpE), .wbSrcE(wbSrcE), .regWriteE(regWriteE),
        .forwardA(forwardA), .forwardB(forwardB), .wbData(wbData),
        .eqE(eqE), .ltE(ltE), .ltuE(ltuE), .targetE(targetE),
        .aluResultM(aluResultM), .rdM(rdM), .addrModeM(addrModeM),
        .storeDataM(storeDataM), .pcPlus4M(pcPlus4M),
        .wbSrcM(wbSrcM), .regWriteM(regWriteM)
    );

    memoryStage memory0 (
        .clk(clk), .rstN(rstN),
        .aluResultM(aluResultM), .storeDataM(storeDataM), .pcPlus4M(pcPlus4M),
        .rdM(rdM), .addrModeM(addrModeM), .wbSrcM(wbSrcM), .regWriteM(regWriteM),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData), .rdW(rdW)
    );

    hazardUnit hazard0 (
        .rs1E(rs1E), .rs2E(rs2E), .rdM(rdM), .rdW(rdW),
        .addrModeM(addrModeM), .branchE(branchE), .jumpE(jumpE),
        .eqE(eqE), .ltE(ltE), .ltuE(ltuE),
        .forwardA(forwardA), .forwardB(forwardB),
        .stall(stall), .flush(flush)
    );

endmodule

//--- logic/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  logic            clk,
    input  logic            rstN,
    input  rvPkg::wordT     aluResultM,
    input  rvPkg::wordT     storeDataM,
    input  rvPkg::wordT     pcPlus4M,
    input  rvPkg::regAddrT  rdM,
    input  rvPkg::addrModeT addrModeM,
    input  rvPkg::wbSrcT    wbSrcM,
    input  logic            regWriteM,
    output logic            wbEn,
    output rvPkg::regAddrT  wbRd,
    output rvPkg::wordT     wbData,
    output rvPkg::regAddrT  rdW
);
    import rvPkg::*;

    wordT                dmem [dmemWords];
    logic [dmemIdxW-1:0] wordIdx;
    logic [1:0]          byteOff;
    logic [3:0]          byteEn;
    wordT                wrData, rdWord, shifted, loadData, wbNext;

    assign wordIdx = aluResultM[2 +: dmemIdxW];
    assign byteOff = aluResultM[1:0];

    // Store data replicated across lanes and the enables pick the lane
    always_comb begin
        byteEn = 4'b0000;
        wrData = storeDataM;
        case (addrModeM)
            modeSb: begin
                byteEn = 4'b0001 << byteOff;
                wrData = {4{storeDataM[7:0]}};
            end
            modeSh: begin
                byteEn = 4'b0011 << {byteOff[1], 1'b0};
                wrData = {2{storeDataM[15:0]}};
            end
            modeSw: byteEn = 4'b1111;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byteEn[i]) begin
                dmem[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
            end
        end
    end

    assign rdWord  = dmem[wordIdx]; // Combinational read
    assign shifted = rdWord >> {byteOff, 3'b000};

    always_comb begin
        case (addrModeM)
            modeLb:  loadData = {{24{shifted[7]}}, shifted[7:0]};
            modeLh:  loadData = {{16{shifted[15]}}, shifted[15:0]};
            modeLbu: loadData = {24'b0, shifted[7:0]};
            modeLhu: loadData = {16'b0, shifted[15:0]};
            default: loadData = rdWord;
        endcase
    end

    always_comb begin
        case (wbSrcM)
            wbMem:   wbNext = loadData;
            wbPc4:   wbNext = pcPlus4M;
            default: wbNext = aluResultM; // wbAlu
        endcase
    end

    // Memory/writeback register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbEn <= 1'b0;
            rdW  <= '0;
        end else begin
            wbEn <= regWriteM && (rdM != '0);
            rdW  <= rdM;
        end
    end

    always_ff @(posedge clk) begin
        wbData <= wbNext;
    end

    assign wbRd = rdW;

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            stall,
    input  rvPkg::regAddrT  rdE,
    input  rvPkg::wordT     rd1E,
    input  rvPkg::wordT     rd2E,
    input  rvPkg::wordT     immE,
    input  rvPkg::wordT     pcE,
    input  rvPkg::aluOpT    aluOpE,
    input  logic            aluSrcAE,
    input  logic            aluSrcBE,
    input  rvPkg::addrModeT addrModeE,
    input  rvPkg::jumpT     jumpE,
    input  rvPkg::wbSrcT    wbSrcE,
    input  logic            regWriteE,
    input  rvPkg::fwdSelT   forwardA,
    input  rvPkg::fwdSelT   forwardB,
    input  rvPkg::wordT     wbData,
    output logic            eqE,
    output logic            ltE,
    output logic            ltuE,
    output rvPkg::wordT     targetE,
    output rvPkg::wordT     aluResultM,
    output rvPkg::regAddrT  rdM,
    output rvPkg::addrModeT addrModeM,
    output rvPkg::wordT     storeDataM,
    output rvPkg::wordT     pcPlus4M,
    output rvPkg::wbSrcT    wbSrcM,
    output logic            regWriteM
);
    import rvPkg::*;

    wordT srcA, srcB;
    wordT aluA, aluB;
    wordT aluResult;

    function automatic wordT fwdMux(
        input fwdSelT sel,
        input wordT   regVal,
        input wordT   memVal,
        input wordT   wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = fwdMux(forwardA, rd1E, aluResultM, wbData);
    assign srcB = fwdMux(forwardB, rd2E, aluResultM, wbData);

    assign aluA = aluSrcAE ? pcE : srcA;
    assign aluB = aluSrcBE ? immE : srcB;

    always_comb begin
        case (aluOpE)
            aluSub:   aluResult = aluA - aluB;
            aluSll:   aluResult = aluA << aluB[4:0];
            aluSlt:   aluResult = wordT'($signed(aluA) < $signed(aluB));
            aluSltu:  aluResult = wordT'(aluA < aluB);
            aluXor:   aluResult = aluA ^ aluB;
            aluSrl:   aluResult = aluA >> aluB[4:0];
            aluSra:   aluResult = $signed(aluA) >>> aluB[4:0];
            aluOr:    aluResult = aluA | aluB;
            aluAnd:   aluResult = aluA & aluB;
            aluPassB: aluResult = aluB;
            default:  aluResult = aluA + aluB; // aluAdd
        endcase
    end

    // Raw compare flags for the hazard unit to judge
    assign eqE  = (srcA == srcB);
    assign ltE  = ($signed(srcA) < $signed(srcB));
    assign ltuE = (srcA < srcB);

    assign targetE = (jumpE == jmpJalr) ? {aluResult[xLen-1:1], 1'b0} : pcE + immE;

    // Execute/memory control takes a bubble while a load-use stall holds execute
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdM       <= '0;
            addrModeM <= modeNone;
            regWriteM <= 1'b0;
        end else if (stall) begin
            rdM       <= '0;
            addrModeM <= modeNone;
            regWriteM <= 1'b0;
        end else begin
            rdM       <= rdE;
            addrModeM <= addrModeE;
            regWriteM <= regWriteE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResult;
        storeDataM <= srcB;
        pcPlus4M   <= pcE + 32'd4; // Link value for JAL/JALR
        wbSrcM     <= wbSrcE;
    end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            stall,
    input  logic            flush,
    input  rvPkg::wordT     instrD,
    input  rvPkg::wordT     pcD,
    input  logic            wbEn,
    input  rvPkg::regAddrT  wbRd,
    input  rvPkg::wordT     wbData,
    output rvPkg::regAddrT  rs1E,
    output rvPkg::regAddrT  rs2E,
    output rvPkg::regAddrT  rdE,
    output rvPkg::wordT     rd1E,
    output rvPkg::wordT     rd2E,
    output rvPkg::wordT     immE,
    output rvPkg::wordT     pcE,
    output rvPkg::aluOpT    aluOpE,
    output logic            aluSrcAE,
    output logic            aluSrcBE,
    output rvPkg::addrModeT addrModeE,
    output rvPkg::branchOpT branchE,
    output rvPkg::jumpT     jumpE,
    output rvPkg::wbSrcT    wbSrcE,
    output logic            regWriteE
);
    import rvPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       useRs1, useRs2;
    regAddrT    rs1D, rs2D, rdD, rdAddrA, rdAddrB;
    wordT       rd1D, rd2D;
    wordT       immI, immS, immB, immU, immJ, immD;
    aluOpT      aluOpD;
    logic       aluSrcAD, aluSrcBD, regWriteD;
    addrModeT   addrModeD;
    branchOpT   branchD;
    jumpT       jumpD;
    wbSrcT      wbSrcD;

    assign opcode   = instrD[6:0];
    assign funct3   = instrD[14:12];
    assign funct7b5 = instrD[30];

    assign immI = {{20{instrD[31]}}, instrD[31:20]};
    assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
    assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
    assign immU = {instrD[31:12], 12'b0};
    assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};

    // Unused fields zeroed to keep false hazards away
    assign rs1D = useRs1 ? instrD[19:15] : '0;
    assign rs2D = useRs2 ? instrD[24:20] : '0;
    assign rdD  = regWriteD ? instrD[11:7] : '0;

    // A stalled execute instruction re-reads its sources here, picking up
    // the value that retires while it waits
    assign rdAddrA = stall ? rs1E : rs1D;
    assign rdAddrB = stall ? rs2E : rs2D;

    regFile rf0 (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (rdAddrA),
        .rs2    (rdAddrB),
        .rd1    (rd1D),
        .rd2    (rd2D),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData)
    );

    function automatic aluOpT aluFn(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    always_comb begin
        aluOpD    = aluAdd;
        aluSrcAD  = 1'b0;
        aluSrcBD  = 1'b1;
        addrModeD = modeNone;
        branchD   = brNone;
        jumpD     = jmpNone;
        wbSrcD    = wbAlu;
        regWriteD = 1'b0;
        useRs1    = 1'b0;
        useRs2    = 1'b0;
        immD      = immI;
        case (opcode)
            opLui: begin
                regWriteD = 1'b1;
                aluOpD    = aluPassB;
                immD      = immU;
            end
            opAuipc: begin
                regWriteD = 1'b1;
                aluSrcAD  = 1'b1; // pc + imm
                immD      = immU;
            end
            opJal: begin
                regWriteD = 1'b1;
                jumpD     = jmpJal;
                wbSrcD    = wbPc4;
                immD      = immJ;
            end
            opJalr: begin
                regWriteD = 1'b1;
                useRs1    = 1'b1;
                jumpD     = jmpJalr;
                wbSrcD    = wbPc4;
            end
            opBranch: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                immD   = immB;
                case (funct3)
                    3'b000:  branchD = brEq;
                    3'b001:  branchD = brNe;
                    3'b100:  branchD = brLt;
                    3'b101:  branchD = brGe;
                    3'b110:  branchD = brLtu;
                    3'b111:  branchD = brGeu;
                    default: branchD = brNone;
                endcase
            end
            opLoad: begin
                regWriteD = 1'b1;
                useRs1    = 1'b1;
                wbSrcD    = wbMem;
                case (funct3)
                    3'b000:  addrModeD = modeLb;
                    3'b001:  addrModeD = modeLh;
                    3'b100:  addrModeD = modeLbu;
                    3'b101:  addrModeD = modeLhu;
                    default: addrModeD = modeLw;
                endcase
            end
            opStore: begin
                useRs1    = 1'b1;
                useRs2    = 1'b1;
                immD      = immS;
                addrModeD = modeSb + addrModeT'(funct3[1:0]); // SB, SH, SW in a row
            end
            opImm: begin
                regWriteD = 1'b1;
                useRs1    = 1'b1;
                aluOpD    = aluFn(funct3, funct7b5 && (funct3 == 3'b101)); // Only SRAI
            end
            opReg: begin
                regWriteD = 1'b1;
                useRs1    = 1'b1;
                useRs2    = 1'b1;
                aluSrcBD  = 1'b0;
                aluOpD    = aluFn(funct3, funct7b5);
            end
            default: ;
        endcase
    end

    // Decode/execute control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rs1E      <= '0;
            rs2E      <= '0;
            rdE       <= '0;
            addrModeE <= modeNone;
            branchE   <= brNone;
            jumpE     <= jmpNone;
            regWriteE <= 1'b0;
        end else if (flush) begin
            rs1E      <= '0;
            rs2E      <= '0;
            rdE       <= '0;
            addrModeE <= modeNone;
            branchE   <= brNone;
            jumpE     <= jmpNone;
            regWriteE <= 1'b0;
        end else if (!stall) begin
            rs1E      <= rs1D;
            rs2E      <= rs2D;
            rdE       <= rdD;
            addrModeE <= addrModeD;
            branchE   <= branchD;
            jumpE     <= jumpD;
            regWriteE <= regWriteD;
        end
    end

    // Decode/execute payload
    always_ff @(posedge clk) begin
        rd1E <= rd1D;
        rd2E <= rd2D;
        if (!stall) begin
            immE     <= immD;
            pcE      <= pcD;
            aluOpE   <= aluOpD;
            aluSrcAE <= aluSrcAD;
            aluSrcBE <= aluSrcBD;
            wbSrcE   <= wbSrcD;
        end
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::regAddrT rs1,
    input  rvPkg::regAddrT rs2,
    output rvPkg::wordT    rd1,
    output rvPkg::wordT    rd2,
    input  logic           wbEn,
    input  rvPkg::regAddrT wbRd,
    input  rvPkg::wordT    wbData
);
    import rvPkg::*;

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbRd != '0)) begin
            regs[wbRd] <= wbData;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rd1 = (rs1 == '0) ? '0 : (wbEn && (wbRd == rs1)) ? wbData : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (wbEn && (wbRd == rs2)) ? wbData : regs[rs2];

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        flush,
    input  rvPkg::wordT targetE,
    output rvPkg::wordT imemAddr,
    input  rvPkg::wordT imemData,
    output rvPkg::wordT instrD,
    output rvPkg::wordT pcD
);
    import rvPkg::*;

    wordT pcF;

    assign imemAddr = pcF; // Instruction word comes back in the same cycle

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= '0;
        end else if (flush) begin
            pcF <= targetE; // Redirect from execute
        end else if (!stall) begin
            pcF <= pcF + 32'd4;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= nopInstr;
            pcD    <= '0;
        end else if (flush) begin
            instrD <= nopInstr; // Wrong-path slot becomes a bubble
            pcD    <= '0;
        end else if (!stall) begin
            instrD <= imemData;
            pcD    <= pcF;
        end
    end

endmodule

//--- hazard/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  rvPkg::regAddrT  rs1E,
    input  rvPkg::regAddrT  rs2E,
    input  rvPkg::regAddrT  rdM,
    input  rvPkg::regAddrT  rdW,
    input  rvPkg::addrModeT addrModeM,
    input  rvPkg::branchOpT branchE,
    input  rvPkg::jumpT     jumpE,
    input  logic            eqE,
    input  logic            ltE,
    input  logic            ltuE,
    output rvPkg::fwdSelT   forwardA,
    output rvPkg::fwdSelT   forwardB,
    output logic            stall,
    output logic            flush
);
    import rvPkg::*;

    logic isLoadM;
    logic branchTaken;

    // Memory stage checked first so the younger result wins
    function automatic fwdSelT pickFwd(
        input regAddrT rs,
        input regAddrT rdMem,
        input regAddrT rdWb
    );
        if (rs == '0) begin
            return fwdReg; // x0 is never forwarded
        end else if (rs == rdMem) begin
            return fwdMem;
        end else if (rs == rdWb) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign forwardA = pickFwd(rs1E, rdM, rdW);
    assign forwardB = pickFwd(rs2E, rdM, rdW);

    // Load result is not ready until it reaches writeback
    assign isLoadM = (addrModeM <= modeLhu);
    assign stall   = isLoadM && (rdM != '0) && ((rdM == rs1E) || (rdM == rs2E));

    always_comb begin
        case (branchE)
            brEq:    branchTaken = eqE;
            brNe:    branchTaken = !eqE;
            brLt:    branchTaken = ltE;
            brGe:    branchTaken = !ltE;
            brLtu:   branchTaken = ltuE;
            brGeu:   branchTaken = !ltuE;
            default: branchTaken = 1'b0;
        endcase
    end

    // Compare flags are stale while the load is still in memory,
    // so the transfer waits for the stall to clear
    assign flush = !stall && (jumpE[1] || branchTaken);

endmodule

//--- common/rvPkg.sv
package rvPkg;

    localparam int xLen      = 32;
    localparam int dmemWords = 256;
    localparam int dmemIdxW  = $clog2(dmemWords);

    typedef logic [xLen-1:0] wordT;
    typedef logic [4:0]      regAddrT;
    typedef logic [1:0]      fwdSelT;
    typedef logic [3:0]      addrModeT;
    typedef logic [2:0]      branchOpT;
    typedef logic [1:0]      jumpT;
    typedef logic [3:0]      aluOpT;
    typedef logic [1:0]      wbSrcT;
    typedef logic [6:0]      opcodeT;

    // Forwarding selects for the execute operands
    localparam fwdSelT fwdReg = 2'b00;
    localparam fwdSelT fwdMem = 2'b01;
    localparam fwdSelT fwdWb  = 2'b10;

    // Loads sit at 0..4 so a single compare spots them
    localparam addrModeT modeLb   = 4'd0;
    localparam addrModeT modeLh   = 4'd1;
    localparam addrModeT modeLw   = 4'd2;
    localparam addrModeT modeLbu  = 4'd3;
    localparam addrModeT modeLhu  = 4'd4;
    localparam addrModeT modeSb   = 4'd5;
    localparam addrModeT modeSh   = 4'd6;
    localparam addrModeT modeSw   = 4'd7;
    localparam addrModeT modeNone = 4'd15;

    localparam branchOpT brNone = 3'd0;
    localparam branchOpT brEq   = 3'd1;
    localparam branchOpT brNe   = 3'd2;
    localparam branchOpT brLt   = 3'd3;
    localparam branchOpT brGe   = 3'd4;
    localparam branchOpT brLtu  = 3'd5;
    localparam branchOpT brGeu  = 3'd6;

    localparam jumpT jmpNone = 2'b00;
    localparam jumpT jmpJal  = 2'b10;
    localparam jumpT jmpJalr = 2'b11;

    localparam aluOpT aluAdd   = 4'd0;
    localparam aluOpT aluSub   = 4'd1;
    localparam aluOpT aluSll   = 4'd2;
    localparam aluOpT aluSlt   = 4'd3;
    localparam aluOpT aluSltu  = 4'd4;
    localparam aluOpT aluXor   = 4'd5;
    localparam aluOpT aluSrl   = 4'd6;
    localparam aluOpT aluSra   = 4'd7;
    localparam aluOpT aluOr    = 4'd8;
    localparam aluOpT aluAnd   = 4'd9;
    localparam aluOpT aluPassB = 4'd10;

    localparam wbSrcT wbAlu = 2'd0;
    localparam wbSrcT wbMem = 2'd1;
    localparam wbSrcT wbPc4 = 2'd2;

    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opReg    = 7'b0110011;

    localparam wordT nopInstr = 32'h0000_0013; // addi x0, x0, 0

endpackage
